// ==== tm1638_proto_pkg.sv ====
// tm1638 protocol package with command codes and serial bit timing
`default_nettype none

package tm1638_proto_pkg;

	// data command, write mode with auto-increment address
	localparam logic [7:0] CMD_DATA_WRITE = 8'h40;

	// data command, key scan read
	localparam logic [7:0] CMD_DATA_READ = 8'h42;

	localparam logic [7:0] CMD_ADDR_BASE = 8'hC0; // address 0
	localparam logic [7:0] CMD_DISP_BASE = 8'h80; // display off, dimmest

	// display control layout, brightness sits in bits 2:0
	localparam int DISP_ON_BIT = 3;

	// one bit is this many phases, each phase CLOCK_FREQ_MHZ cycles
	// clk low for the first half, high for the second
	localparam int PHASES_PER_BIT = 8;

	localparam int SCAN_BYTES = 4; // bytes returned by a key scan

endpackage

`default_nettype wire

// ==== panel_pkg.sv ====
// led&key panel package with display geometry, key map and host widths
`default_nettype none

package panel_pkg;

	localparam int DISP_BYTES = 16; // 8 digits + 8 leds, interleaved
	localparam int ADDR_W     = 4;
	localparam int KEYS       = 8;
	localparam int BRIGHT_W   = 3;

	typedef logic [KEYS-1:0] key_vec_t;

	// key map: key k (k = 0..3) is bit KEY_LO_BIT of scan byte k,
	// key k+4 is bit KEY_HI_BIT of scan byte k
	localparam int KEY_LO_BIT = 0;
	localparam int KEY_HI_BIT = 4;

endpackage

`default_nettype wire

// ==== tm1638_serial.sv ====
// tm1638 serial shifter, sends or receives one byte LSB first per start strobe
`timescale 1ns/100ps
`default_nettype none

module tm1638_serial #(
	parameter int CLOCK_FREQ_MHZ = 12
) (
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_start,
	input  wire        i_read,
	input  wire  [7:0] i_byte,
	input  wire        i_dio_in,
	output logic       o_done,
	output logic [7:0] o_rx_byte,
	output logic       o_tm_clk,
	output logic       o_dio_out,
	output logic       o_dio_oe
);
	import tm1638_proto_pkg::*;

	localparam int DIV_W = $clog2(CLOCK_FREQ_MHZ + 1);
	localparam int PH_W  = $clog2(PHASES_PER_BIT);

	logic             active;
	logic             rd;      // current byte is a receive
	logic [DIV_W-1:0] div;     // cycles within a phase
	logic [PH_W-1:0]  phase;   // phase within a bit
	logic [2:0]       bit_cnt;
	logic [7:0]       shreg;
	logic             tick;
	logic             bit_end;
	logic             sample;

	assign tick    = (div == DIV_W'(CLOCK_FREQ_MHZ - 1));
	assign bit_end = tick && (phase == PH_W'(PHASES_PER_BIT - 1));

	// receive point sits 2 phases before the bit ends, chip drove on the falling edge
	assign sample = active && rd && (div == '0) && (phase == PH_W'(PHASES_PER_BIT - 2));

	assign o_done    = active && bit_end && (bit_cnt == 3'd7);
	assign o_rx_byte = shreg;
	assign o_tm_clk  = !active || (phase >= PH_W'(PHASES_PER_BIT / 2)); // idles high
	assign o_dio_out = shreg[0];
	assign o_dio_oe  = active && !rd;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active  <= 1'b0;
			rd      <= 1'b0;
			div     <= '0;
			phase   <= '0;
			bit_cnt <= '0;
			shreg   <= '0;
		end else if (!active) begin
			if (i_start) begin
				active  <= 1'b1;
				rd      <= i_read;
				div     <= '0;
				phase   <= '0;
				bit_cnt <= '0;
				shreg   <= i_byte; // bit 0 on the line from the first cycle
			end
		end else begin
			if (tick)
				div <= '0;
			else
				div <= div + 1'b1;

			if (bit_end)
				phase <= '0;
			else if (tick)
				phase <= phase + 1'b1;

			if (sample)
				shreg <= {i_dio_in, shreg[7:1]}; // lsb arrives first

			if (bit_end) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (!rd)
					shreg <= {1'b0, shreg[7:1]};
				if (bit_cnt == 3'd7)
					active <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== display_ram.sv ====
// display image storage, 16 bytes written by the host, registered read port
`timescale 1ns/100ps
`default_nettype none

module display_ram (
	input  wire                         i_clk,
	input  wire                         i_rst_n,
	input  wire                         i_wr_en,
	input  wire  [panel_pkg::ADDR_W-1:0] i_wr_addr,
	input  wire  [7:0]                  i_wr_data,
	input  wire  [panel_pkg::ADDR_W-1:0] i_rd_addr,
	output logic [7:0]                  o_rd_data
);
	import panel_pkg::*;

	logic [7:0] mem [DISP_BYTES];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < DISP_BYTES; i++)
				mem[i] <= '0; // blank panel after reset
			o_rd_data <= '0;
		end else begin
			if (i_wr_en)
				mem[i_wr_addr] <= i_wr_data;
			o_rd_data <= mem[i_rd_addr]; // one cycle latency
		end
	end

endmodule

`default_nettype wire

// ==== key_decoder.sv ====
// key decoder, collects scan bytes into the key vector and flags new presses
`timescale 1ns/100ps
`default_nettype none

module key_decoder (
	input  wire                 i_clk,
	input  wire                 i_rst_n,
	input  wire                 i_byte_valid,
	input  wire  [1:0]          i_index,
	input  wire  [7:0]          i_byte,
	input  wire                 i_commit,
	output panel_pkg::key_vec_t o_keys,
	output panel_pkg::key_vec_t o_key_press
);
	import panel_pkg::*;

	localparam int KW = $clog2(KEYS);

	key_vec_t      pend; // keys gathered during the current scan
	logic [KW-1:0] idx_lo;
	logic [KW-1:0] idx_hi;

	assign idx_lo = KW'(i_index);
	assign idx_hi = KW'(i_index) + KW'(KEYS / 2);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pend        <= '0;
			o_keys      <= '0;
			o_key_press <= '0;
		end else begin
			if (i_byte_valid) begin
				pend[idx_lo] <= i_byte[KEY_LO_BIT];
				pend[idx_hi] <= i_byte[KEY_HI_BIT];
			end

			o_key_press <= '0;
			if (i_commit) begin
				o_keys      <= pend;
				o_key_press <= pend & ~o_keys; // rising keys only
			end
		end
	end

endmodule

`default_nettype wire

// ==== panel_sequencer.sv ====
// panel sequencer FSM, runs strobe and orders the commands of one refresh frame
`timescale 1ns/100ps
`default_nettype none

module panel_sequencer #(
	parameter int CLOCK_FREQ_MHZ = 12
) (
	input  wire                           i_clk,
	input  wire                           i_rst_n,
	input  wire                           i_refresh,
	input  wire  [panel_pkg::BRIGHT_W-1:0] i_brightness,
	input  wire                           i_display_on,
	input  wire                           i_done,
	input  wire  [7:0]                    i_rx_byte,
	input  wire  [7:0]                    i_ram_data,
	output logic                          o_busy,
	output logic                          o_tm_stb,
	output logic                          o_start,
	output logic                          o_read,
	output logic [7:0]                    o_byte,
	output logic [panel_pkg::ADDR_W-1:0]   o_ram_addr,
	output logic                          o_key_valid,
	output logic [1:0]                    o_key_index,
	output logic [7:0]                    o_key_byte,
	output logic                          o_key_commit
);
	import tm1638_proto_pkg::*;
	import panel_pkg::*;

	localparam int BIT_CYC   = PHASES_PER_BIT * CLOCK_FREQ_MHZ;
	localparam int CNT_W     = $clog2(BIT_CYC);
	localparam int SETUP_CNT = BIT_CYC / 2 - 2; // stb low to first clock edge
	localparam int HOLD_CNT  = BIT_CYC / 2 - 1; // last bit to stb high
	localparam int GAP_CNT   = BIT_CYC - 1;
	localparam int RWAIT_CNT = BIT_CYC - 2;

	typedef enum logic [2:0] {
		ST_IDLE, ST_SETUP, ST_CMD, ST_DATA, ST_RWAIT, ST_READ, ST_HOLD, ST_GAP
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [1:0]       cmd;    // 0 data write, 1 address + image, 2 display, 3 key read
	logic [1:0]       rd_cnt;
	logic [7:0]       disp_byte;
	logic [7:0]       cmd_byte;

	assign disp_byte = CMD_DISP_BASE | (8'(i_display_on) << DISP_ON_BIT) | 8'(i_brightness);

	always_comb begin
		case (cmd)
			2'd0:    cmd_byte = CMD_DATA_WRITE;
			2'd1:    cmd_byte = CMD_ADDR_BASE;
			2'd2:    cmd_byte = disp_byte;
			default: cmd_byte = CMD_DATA_READ;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= ST_IDLE;
			cnt          <= '0;
			cmd          <= '0;
			rd_cnt       <= '0;
			o_busy       <= 1'b0;
			o_tm_stb     <= 1'b1;
			o_start      <= 1'b0;
			o_read       <= 1'b0;
			o_byte       <= '0;
			o_ram_addr   <= '0;
			o_key_valid  <= 1'b0;
			o_key_index  <= '0;
			o_key_byte   <= '0;
			o_key_commit <= 1'b0;
		end else begin
			o_start      <= 1'b0;
			o_key_valid  <= 1'b0;
			o_key_commit <= 1'b0;
			if (cnt != '0)
				cnt <= cnt - 1'b1;

			case (state)
				ST_IDLE: if (i_refresh) begin
					o_busy     <= 1'b1;
					o_tm_stb   <= 1'b0;
					cmd        <= '0;
					o_ram_addr <= '0;
					cnt        <= CNT_W'(SETUP_CNT);
					state      <= ST_SETUP;
				end
				ST_SETUP: if (cnt == '0) begin
					o_start <= 1'b1;
					o_read  <= 1'b0;
					o_byte  <= cmd_byte; // display levels sampled here
					state   <= ST_CMD;
				end
				ST_CMD: if (i_done) begin
					case (cmd)
						2'd1: begin
							o_start    <= 1'b1;
							o_byte     <= i_ram_data; // address 0 already fetched
							o_ram_addr <= o_ram_addr + 1'b1;
							state      <= ST_DATA;
						end
						2'd3: begin
							cnt   <= CNT_W'(RWAIT_CNT);
							state <= ST_RWAIT;
						end
						default: begin
							cnt   <= CNT_W'(HOLD_CNT);
							state <= ST_HOLD;
						end
					endcase
				end
				ST_DATA: if (i_done) begin
					if (o_ram_addr == ADDR_W'(DISP_BYTES)) begin // wrapped, image sent
						cnt   <= CNT_W'(HOLD_CNT);
						state <= ST_HOLD;
					end else begin
						o_start    <= 1'b1;
						o_byte     <= i_ram_data;
						o_ram_addr <= o_ram_addr + 1'b1;
					end
				end
				ST_RWAIT: if (cnt == '0) begin
					o_start <= 1'b1;
					o_read  <= 1'b1;
					rd_cnt  <= '0;
					state   <= ST_READ;
				end
				ST_READ: if (i_done) begin
					o_key_valid <= 1'b1;
					o_key_index <= rd_cnt;
					o_key_byte  <= i_rx_byte;
					if (rd_cnt == 2'(SCAN_BYTES - 1)) begin
						cnt   <= CNT_W'(HOLD_CNT);
						state <= ST_HOLD;
					end else begin
						o_start <= 1'b1;
						rd_cnt  <= rd_cnt + 1'b1;
					end
				end
				ST_HOLD: if (cnt == '0) begin
					o_tm_stb     <= 1'b1;
					o_key_commit <= (cmd == 2'd3);
					cnt          <= CNT_W'(GAP_CNT);
					state        <= ST_GAP;
				end
				ST_GAP: if (cnt == '0) begin
					if (cmd == 2'd3) begin
						o_busy <= 1'b0; // keys already committed
						state  <= ST_IDLE;
					end else begin
						cmd      <= cmd + 1'b1;
						o_tm_stb <= 1'b0;
						cnt      <= CNT_W'(SETUP_CNT);
						state    <= ST_SETUP;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tm1638_panel.sv ====
// tm1638 led&key panel controller top, display refresh and key scan
`timescale 1ns/100ps
`default_nettype none

module tm1638_panel #(
	parameter int CLOCK_FREQ_MHZ = 12
) (
	input  wire                           i_clk,
	input  wire                           i_rst_n,
	input  wire                           i_wr_en,
	input  wire  [panel_pkg::ADDR_W-1:0]   i_wr_addr,
	input  wire  [7:0]                    i_wr_data,
	input  wire  [panel_pkg::BRIGHT_W-1:0] i_brightness,
	input  wire                           i_display_on,
	input  wire                           i_refresh,
	output logic                          o_busy,
	output panel_pkg::key_vec_t           o_keys,
	output panel_pkg::key_vec_t           o_key_press,
	output logic                          o_tm_stb,
	output logic                          o_tm_clk,
	output logic                          o_dio_out,
	output logic                          o_dio_oe,
	input  wire                           i_dio_in
);
	import panel_pkg::*;

	logic              s_start;
	logic              s_read;
	logic [7:0]        s_byte;
	logic              s_done;
	logic [7:0]        s_rx_byte;
	logic [ADDR_W-1:0] r_addr;
	logic [7:0]        r_data;
	logic              k_byte_valid;
	logic [1:0]        k_index;
	logic [7:0]        k_byte;
	logic              k_commit;

	panel_sequencer #(
		.CLOCK_FREQ_MHZ(CLOCK_FREQ_MHZ)
	) u_seq (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_refresh(i_refresh), .i_brightness(i_brightness), .i_display_on(i_display_on),
		.i_done(s_done), .i_rx_byte(s_rx_byte), .i_ram_data(r_data),
		.o_busy(o_busy), .o_tm_stb(o_tm_stb),
		.o_start(s_start), .o_read(s_read), .o_byte(s_byte), .o_ram_addr(r_addr),
		.o_key_valid(k_byte_valid), .o_key_index(k_index), .o_key_byte(k_byte),
		.o_key_commit(k_commit)
	);

	tm1638_serial #(
		.CLOCK_FREQ_MHZ(CLOCK_FREQ_MHZ)
	) u_serial (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_start(s_start), .i_read(s_read), .i_byte(s_byte), .i_dio_in(i_dio_in),
		.o_done(s_done), .o_rx_byte(s_rx_byte),
		.o_tm_clk(o_tm_clk), .o_dio_out(o_dio_out), .o_dio_oe(o_dio_oe)
	);

	display_ram u_ram (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
		.i_rd_addr(r_addr), .o_rd_data(r_data)
	);

	key_decoder u_keys (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_byte_valid(k_byte_valid), .i_index(k_index), .i_byte(k_byte),
		.i_commit(k_commit), .o_keys(o_keys), .o_key_press(o_key_press)
	);

endmodule

`default_nettype wire

// ==== tb_panel_checker.sv ====
// panel checker, decodes serial commands and compares them and the host outputs with the models
`timescale 1ns/100ps
`default_nettype none

module tb_panel_checker (
	input  wire          i_clk,
	input  wire          i_rst_n,
	input  wire          i_tm_stb,
	input  wire          i_tm_clk,
	input  wire          i_dio_out,
	input  wire          i_dio_oe,
	input  wire          i_dio_in,
	input  wire          i_busy,
	input  wire  [7:0]   i_keys,
	input  wire  [7:0]   i_key_press,
	input  wire  [127:0] i_exp_image,
	input  wire  [7:0]   i_exp_disp,
	input  wire  [7:0]   i_exp_keys,
	input  wire  [7:0]   i_prev_keys,
	input  wire  [31:0]  i_scan,
	input  wire  [31:0]  i_accepted,
	output int           o_errors
);
	import tm1638_proto_pkg::*;

	logic [7:0] bytes [$]; // bytes of the current command
	logic [7:0] cur;
	int         nbits;
	int         cmd_idx;
	int         press_cnt;
	int         frames;
	logic       stb_q;
	logic       clk_q;
	logic       busy_q;

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
			o_errors++;
		end
	endtask

	task automatic complain(input string what);
		$display("%s", what);
		o_errors++;
	endtask

	task automatic sample_bit();
		if (cmd_idx == 3 && bytes.size() != 0) begin
			if (i_dio_oe)
				complain($sformatf("frame %0d: data line driven during key read", frames));
			cur[nbits] = i_dio_in;
		end else begin
			if (!i_dio_oe)
				complain($sformatf("frame %0d: data line released in a write", frames));
			cur[nbits] = i_dio_out; // lsb first
		end
		nbits++;
		if (nbits == 8) begin
			bytes.push_back(cur);
			nbits = 0;
		end
	endtask

	task automatic check_command();
		string tag;
		tag = $sformatf("frame %0d cmd %0d", frames, cmd_idx);
		if (nbits != 0)
			complain($sformatf("%s ended inside a byte", tag));
		case (cmd_idx)
			0: begin
				compare({tag, " length"}, 32'd1, 32'(bytes.size()));
				compare({tag, " data write"}, 32'(CMD_DATA_WRITE), 32'(bytes[0]));
			end
			1: begin
				compare({tag, " length"}, 32'd17, 32'(bytes.size()));
				compare({tag, " address"}, 32'(CMD_ADDR_BASE), 32'(bytes[0]));
				for (int i = 0; i < 16 && i + 1 < bytes.size(); i++)
					compare($sformatf("%s image byte %0d", tag, i),
						32'(i_exp_image[8*i +: 8]), 32'(bytes[i+1]));
			end
			2: begin
				compare({tag, " length"}, 32'd1, 32'(bytes.size()));
				compare({tag, " display control"}, 32'(i_exp_disp), 32'(bytes[0]));
			end
			3: begin
				compare({tag, " length"}, 32'd5, 32'(bytes.size()));
				compare({tag, " key read"}, 32'(CMD_DATA_READ), 32'(bytes[0]));
				for (int k = 0; k < SCAN_BYTES && k + 1 < bytes.size(); k++)
					compare($sformatf("%s scan byte %0d", tag, k),
						32'(i_scan[8*k +: 8]), 32'(bytes[k+1]));
			end
			default: complain($sformatf("%s is an extra command", tag));
		endcase
		cmd_idx++;
	endtask

	task automatic check_frame_end();
		logic [7:0] fresh;
		fresh = i_exp_keys & ~i_prev_keys;
		if (cmd_idx != 4)
			complain($sformatf("frame %0d ended after %0d commands", frames, cmd_idx));
		compare($sformatf("frame %0d keys", frames), 32'(i_exp_keys), 32'(i_keys));
		compare($sformatf("frame %0d press count", frames),
			(fresh != '0) ? 32'd1 : 32'd0, 32'(press_cnt));
		frames++;
		cmd_idx   = 0;
		press_cnt = 0;
	endtask

	initial begin
		int t;
		o_errors  = 0;
		nbits     = 0;
		cmd_idx   = 0;
		press_cnt = 0;
		frames    = 0;
		cur       = '0;
		stb_q     = 1'b1;
		clk_q     = 1'b1;
		busy_q    = 1'b0;
		t = 0;
		while (i_rst_n !== 1'b1 && t < 100) begin
			@(negedge i_clk);
			t++;
		end
		if (i_rst_n !== 1'b1)
			complain("reset was never released");
		@(negedge i_clk);
		compare("reset stb", 32'd1, 32'(i_tm_stb));
		compare("reset tm clk", 32'd1, 32'(i_tm_clk));
		compare("reset dio oe", 32'd0, 32'(i_dio_oe));
		compare("reset busy", 32'd0, 32'(i_busy));
		compare("reset keys", 32'd0, 32'(i_keys));
		compare("reset key press", 32'd0, 32'(i_key_press));
		forever begin
			@(posedge i_clk); // values read here are from the previous cycle
			if (stb_q && !i_tm_stb) begin
				bytes.delete();
				nbits = 0;
			end
			if (!i_tm_stb && !clk_q && i_tm_clk)
				sample_bit();
			if (!stb_q && i_tm_stb)
				check_command();
			if (i_key_press != '0) begin
				press_cnt++;
				compare($sformatf("frame %0d key press", frames),
					32'(i_exp_keys & ~i_prev_keys), 32'(i_key_press));
			end
			if (!busy_q && i_busy)
				compare("frames started", i_accepted, 32'(frames + 1));
			if (busy_q && !i_busy)
				check_frame_end();
			stb_q  = i_tm_stb;
			clk_q  = i_tm_clk;
			busy_q = i_busy;
		end
	end

endmodule

`default_nettype wire

// ==== tb_tm1638_panel.sv ====
// testbench top for the tm1638 panel with host model, chip model and random frames
`timescale 1ns/100ps
`default_nettype none

module tb_tm1638_panel #(
	parameter int          FREQ = 1,
	parameter logic [31:0] SEED = 32'h2e08
);
	import tm1638_proto_pkg::*;
	import panel_pkg::*;

	localparam int FRAMES  = 8;
	localparam int TIMEOUT = 4000 * FREQ;

	logic              clk;
	logic              rst_n;
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [7:0]        wr_data;
	logic [BRIGHT_W-1:0] brightness;
	logic              display_on;
	logic              refresh;
	logic              busy;
	key_vec_t          keys;
	key_vec_t          key_press;
	logic              tm_stb;
	logic              tm_clk;
	logic              dio_out;
	logic              dio_oe;
	logic              dio_in;

	logic [31:0]  lfsr;
	logic [127:0] image_flat; // host image with byte i at bits 8i+7..8i
	logic [7:0]   exp_disp;
	key_vec_t     exp_keys;
	key_vec_t     prev_keys;
	logic [31:0]  scan;       // chip key matrix with scan byte k at bits 8k+7..8k
	logic [31:0]  accepted;
	int           tb_errors;
	int           chk_errors;
	logic         timed_out;

	tm1638_panel #(.CLOCK_FREQ_MHZ(FREQ)) UUT (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_brightness(brightness), .i_display_on(display_on), .i_refresh(refresh),
		.o_busy(busy), .o_keys(keys), .o_key_press(key_press),
		.o_tm_stb(tm_stb), .o_tm_clk(tm_clk), .o_dio_out(dio_out), .o_dio_oe(dio_oe),
		.i_dio_in(dio_in)
	);

	tb_panel_checker u_checker (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_tm_stb(tm_stb), .i_tm_clk(tm_clk), .i_dio_out(dio_out), .i_dio_oe(dio_oe),
		.i_dio_in(dio_in), .i_busy(busy), .i_keys(keys), .i_key_press(key_press),
		.i_exp_image(image_flat), .i_exp_disp(exp_disp), .i_exp_keys(exp_keys),
		.i_prev_keys(prev_keys), .i_scan(scan), .i_accepted(accepted), .o_errors(chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// key k from bit 0 of scan byte k, key k+4 from bit 4
	function automatic key_vec_t keys_from_scan(input logic [31:0] s);
		key_vec_t k;
		for (int i = 0; i < KEYS / 2; i++) begin
			k[i]            = s[8*i + KEY_LO_BIT];
			k[i + KEYS / 2] = s[8*i + KEY_HI_BIT];
		end
		return k;
	endfunction

	task automatic wait_busy(input logic level, input string what);
		int t;
		t = 0;
		while (busy !== level && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (busy !== level) begin
			$display("timeout while waiting for %s", what);
			tb_errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic run_frame(input logic full);
		logic [31:0] r;
		int          n;
		n = full ? DISP_BYTES : 5;
		for (int i = 0; i < n; i++) begin
			rand_bits(12, r);
			wr_en   = 1'b1;
			wr_addr = full ? ADDR_W'(i) : r[11:8];
			wr_data = r[7:0];
			image_flat[{wr_addr, 3'b000} +: 8] = wr_data;
			@(negedge clk);
		end
		wr_en = 1'b0;
		rand_bits(4, r);
		brightness = r[2:0];
		display_on = r[3];
		exp_disp   = CMD_DISP_BASE + (display_on ? 8'd8 : 8'd0) + 8'(brightness);
		rand_bits(32, r);
		scan      = r;
		prev_keys = exp_keys;
		exp_keys  = keys_from_scan(r);
		refresh  = 1'b1;
		accepted = accepted + 1'b1;
		@(negedge clk);
		refresh = 1'b0;
		wait_busy(1'b1, "frame start");
		if (timed_out)
			return;
		repeat (3) @(negedge clk);
		refresh = 1'b1; // ignored while the frame runs
		@(negedge clk);
		refresh = 1'b0;
		wait_busy(1'b0, "frame end");
		repeat (4) @(negedge clk); // checker sees the end before models move
	endtask

	// chip model drives the next scan bit when the serial clock falls in a read
	initial begin
		int   rd_bit;
		logic tm_clk_q;
		dio_in   = 1'b1;
		rd_bit   = 0;
		tm_clk_q = 1'b1;
		forever begin
			@(negedge clk);
			if (tm_stb)
				rd_bit = 0;
			else if (tm_clk_q && !tm_clk && !dio_oe && rd_bit < 32) begin
				dio_in = scan[rd_bit];
				rd_bit++;
			end
			tm_clk_q = tm_clk;
		end
	end

	initial begin
		rst_n      = 1'b0;
		wr_en      = 1'b0;
		wr_addr    = '0;
		wr_data    = '0;
		brightness = '0;
		display_on = 1'b0;
		refresh    = 1'b0;
		lfsr       = SEED;
		image_flat = '0;
		exp_disp   = CMD_DISP_BASE;
		exp_keys   = '0;
		prev_keys  = '0;
		scan       = '0;
		accepted   = '0;
		tb_errors  = 0;
		timed_out  = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		for (int f = 0; f < FRAMES && !timed_out; f++)
			run_frame(f == 0);
		repeat (4) @(negedge clk);
		$display("errors: %0d in checks, %0d in testbench, %0d frames",
			chk_errors, tb_errors, accepted);
		if (chk_errors + tb_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tm1638_panel.f ====
tm1638_proto_pkg.sv
panel_pkg.sv
tm1638_serial.sv
display_ram.sv
key_decoder.sv
panel_sequencer.sv
tm1638_panel.sv
tb_panel_checker.sv
tb_tm1638_panel.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tm1638_panel
FREQ      ?= 1
SEED      ?= 11784
OBJ_DIR   ?= obj_dir
FILELIST  ?= tm1638_panel.f
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP) (FREQ=$(FREQ) SEED=$(SEED))"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-GFREQ=$(FREQ) -GSEED=$(SEED) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
